// ==== sim.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/control_unit.sv
logic/datapath.sv
logic/memory_control.sv
logic/cpu_top.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/register_file.sv
      - logic/alu.sv
      - logic/control_unit.sv
      - logic/datapath.sv
      - logic/memory_control.sv
      - logic/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv

// ==== test/cpu_tb.sv ====
// Testbench for the pipelined MIPS subset processor
// Runs one program with a unified RAM model, without and with wait states
`timescale 1ns/100ps

module cpu_tb;

    localparam int          data_base = 'h800;
    localparam logic [31:0] halt_word = 32'hffff_ffff;

    // MIPS opcodes and R-type function codes
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_xori  = 6'h0e;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_nor   = 6'h27;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam logic [5:0] fn_sltu  = 6'h2b;

    logic        CLK;
    logic        rst_n;
    logic [31:0] mem_rdata;
    logic        mem_ready;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        halt;

    logic [31:0] ram [0:1023];
    logic [31:0] prog [$];
    int          chk_addr [$];
    logic [31:0] chk_val [$];
    string       chk_name [$];
    int          jal_at;
    integer      seed;
    int          wait_left;
    bit          wait_mode;
    bit          timed_out;
    int          n_pass;
    int          n_fail;

    cpu_top dut (
        .CLK(CLK), .rst_n(rst_n), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .halt(halt)
    );

    always #20 CLK = ~CLK;

    // Unified RAM, read data valid in the same cycle of a read
    assign mem_rdata = mem_ren ? ram[mem_addr[11:2]] : 32'h0000_0000;

    always @(posedge CLK) begin
        if (mem_wen && mem_ready) begin
            ram[mem_addr[11:2]] <= mem_wdata;
        end
    end

    // Ready after 0 to 7 wait cycles per access in random mode
    always @(posedge CLK) begin
        #1;
        if (!wait_mode) begin
            mem_ready = 1'b1;
        end else begin
            if (mem_ready) begin
                wait_left = $random(seed) & 7;
            end else begin
                wait_left = wait_left - 1;
            end
            mem_ready = (wait_left == 0);
        end
    end

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sh,
                                               input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [5:0] op, input int idx);
        logic [25:0] field;
        field = idx;
        return {op, field};
    endfunction

    // Background word for every RAM location
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc0de_0000 | idx;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic emit_nops(input int n);
        repeat (n) begin
            emit(32'h0000_0000);
        end
    endtask

    task automatic add_check(input int off, input logic [31:0] val, input string name);
        chk_addr.push_back(data_base + off);
        chk_val.push_back(val);
        chk_name.push_back(name);
    endtask

    task automatic build_program();
        int jr_set_at;
        int jr_at;
        // Operands, r0 write and the jr target register
        emit(itype_word(op_addiu, 0, 1, data_base));
        emit(itype_word(op_addiu, 0, 2, 16'h1234));
        emit(itype_word(op_addiu, 0, 3, 16'hfffb));
        emit(itype_word(op_lui, 0, 4, 16'h8000));
        emit(itype_word(op_ori, 0, 5, 16'hf0f0));
        emit(itype_word(op_addiu, 0, 0, 16'h0007));
        jr_set_at = prog.size();
        emit(32'h0000_0000);
        // ALU operations
        emit(rtype_word(2, 3, 6, 0, fn_addu));
        emit(rtype_word(2, 3, 7, 0, fn_subu));
        emit(rtype_word(2, 5, 8, 0, fn_and));
        emit(rtype_word(2, 5, 9, 0, fn_or));
        emit(rtype_word(2, 5, 10, 0, fn_xor));
        emit(rtype_word(2, 5, 11, 0, fn_nor));
        emit(rtype_word(3, 2, 12, 0, fn_slt));
        emit(rtype_word(3, 2, 13, 0, fn_sltu));
        emit(rtype_word(0, 2, 14, 4, fn_sll));
        emit(rtype_word(0, 4, 15, 3, fn_srl));
        emit(itype_word(op_andi, 3, 16, 16'hff00));
        emit(itype_word(op_xori, 2, 17, 16'hffff));
        emit(itype_word(op_slti, 3, 18, 16'hfffc));
        emit(itype_word(op_slti, 2, 19, 16'h0100));
        emit_nops(2);
        emit(itype_word(op_sw, 1, 6, 0));
        emit(itype_word(op_sw, 1, 7, 4));
        emit(itype_word(op_sw, 1, 8, 8));
        emit(itype_word(op_sw, 1, 9, 12));
        emit(itype_word(op_sw, 1, 10, 16));
        emit(itype_word(op_sw, 1, 11, 20));
        emit(itype_word(op_sw, 1, 12, 24));
        emit(itype_word(op_sw, 1, 13, 28));
        emit(itype_word(op_sw, 1, 14, 32));
        emit(itype_word(op_sw, 1, 15, 36));
        emit(itype_word(op_sw, 1, 16, 40));
        emit(itype_word(op_sw, 1, 17, 44));
        emit(itype_word(op_sw, 1, 18, 48));
        emit(itype_word(op_sw, 1, 19, 52));
        emit(itype_word(op_sw, 1, 0, 56));
        emit(itype_word(op_sw, 1, 4, 60));
        emit(itype_word(op_sw, 1, 3, 64));
        emit(itype_word(op_sw, 1, 5, 68));
        // Load, store back, reload, store again
        emit(itype_word(op_lw, 1, 20, 4));
        emit_nops(2);
        emit(itype_word(op_sw, 1, 20, 72));
        emit(itype_word(op_lw, 1, 21, 72));
        emit_nops(2);
        emit(itype_word(op_sw, 1, 21, 76));
        // Taken beq: three slots, two skipped
        emit(itype_word(op_beq, 2, 2, 5));
        emit(itype_word(op_addiu, 0, 22, 16'h0011));
        emit(itype_word(op_addiu, 0, 23, 16'h0022));
        emit(itype_word(op_addiu, 0, 24, 16'h0033));
        emit(itype_word(op_addiu, 0, 25, 16'h0044));
        emit(itype_word(op_addiu, 0, 25, 16'h0055));
        // Not-taken bne would skip the marker
        emit(itype_word(op_bne, 2, 2, 5));
        emit_nops(3);
        emit(itype_word(op_addiu, 0, 26, 16'h0066));
        emit_nops(1);
        jal_at = prog.size();
        emit(jtype_word(op_jal, jal_at + 8));
        emit(itype_word(op_addiu, 0, 27, 16'h0077));
        emit_nops(2);
        emit(itype_word(op_addiu, 0, 28, 16'h00bb));
        emit_nops(3);
        emit(itype_word(op_addiu, 0, 29, 16'h0099));
        emit(jtype_word(op_j, prog.size() + 5));
        emit_nops(3);
        emit(itype_word(op_addiu, 0, 28, 16'h00cc));
        jr_at = prog.size();
        emit(rtype_word(30, 0, 0, 0, fn_jr));
        emit_nops(3);
        emit(itype_word(op_addiu, 0, 28, 16'h00aa));
        prog[jr_set_at] = itype_word(op_addiu, 0, 30, (jr_at + 5) * 4);
        emit(itype_word(op_sw, 1, 22, 80));
        emit(itype_word(op_sw, 1, 23, 84));
        emit(itype_word(op_sw, 1, 24, 88));
        emit(itype_word(op_sw, 1, 25, 92));
        emit(itype_word(op_sw, 1, 26, 96));
        emit(itype_word(op_sw, 1, 27, 100));
        emit(itype_word(op_sw, 1, 28, 104));
        emit(itype_word(op_sw, 1, 29, 108));
        emit(itype_word(op_sw, 1, 31, 112));
        emit(halt_word);
        emit_nops(3);
        // Must never reach memory
        emit(itype_word(op_sw, 1, 2, 116));
    endtask

    task automatic build_checks();
        add_check(0, 32'h1234 + 32'hffff_fffb, "addu");
        add_check(4, 32'h1234 - 32'hffff_fffb, "subu");
        add_check(8, 32'h1234 & 32'hf0f0, "and");
        add_check(12, 32'h1234 | 32'hf0f0, "or");
        add_check(16, 32'h1234 ^ 32'hf0f0, "xor");
        add_check(20, ~(32'h1234 | 32'hf0f0), "nor");
        add_check(24, 32'd1, "slt");
        add_check(28, 32'd0, "sltu");
        add_check(32, 32'h1234 << 4, "sll");
        add_check(36, 32'h8000_0000 >> 3, "srl");
        add_check(40, 32'hffff_fffb & 32'h0000_ff00, "andi");
        add_check(44, 32'h1234 ^ 32'h0000_ffff, "xori");
        add_check(48, 32'd1, "slti_neg");
        add_check(52, 32'd0, "slti_pos");
        add_check(56, 32'd0, "zero_reg");
        add_check(60, 32'h8000_0000, "lui");
        add_check(64, 32'hffff_fffb, "addiu_neg");
        add_check(68, 32'h0000_f0f0, "ori");
        add_check(72, 32'h1234 - 32'hffff_fffb, "load_store");
        add_check(76, 32'h1234 - 32'hffff_fffb, "reload");
        add_check(80, 32'h11, "beq_slot1");
        add_check(84, 32'h22, "beq_slot2");
        add_check(88, 32'h33, "beq_slot3");
        add_check(92, 32'd0, "beq_skip");
        add_check(96, 32'h66, "bne_fall");
        add_check(100, 32'h77, "jal_slot");
        add_check(104, 32'd0, "jump_skip");
        add_check(108, 32'h99, "jal_target");
        add_check(112, (jal_at + 1) * 4, "link");
        add_check(116, fill_word((data_base + 116) >> 2), "halt_guard");
    endtask

    task automatic load_memory();
        for (int a = 0; a < 1024; a++) begin
            ram[a] = fill_word(a);
        end
        for (int a = 0; a < prog.size(); a++) begin
            ram[a] = prog[a];
        end
    endtask

    task automatic run_pass(input int pass_no, input bit random_waits, output bit late);
        int cycles;
        int limit;
        wait_mode = random_waits;
        seed = 32'h2a4d;
        @(posedge CLK);
        #1;
        rst_n = 1'b0;
        load_memory();
        repeat (8) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        // Each word at most 5 steps of up to 8 cycles
        limit = prog.size() * 5 * 8;
        cycles = 0;
        while (!halt && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        late = !halt;
        if (late) begin
            $display("Pass %0d: halt never came within %0d cycles", pass_no, limit);
        end else begin
            $display("Pass %0d: halted after %0d cycles", pass_no, cycles);
        end
    endtask

    task automatic check_results(input int pass_no);
        logic [31:0] got;
        repeat (10) @(negedge CLK);
        assert (halt === 1'b1) begin
            n_pass++;
            $display("Pass %0d halt_sticky ok", pass_no);
        end else begin
            n_fail++;
            $display("Pass %0d: halt dropped after the program stopped", pass_no);
        end
        for (int i = 0; i < chk_addr.size(); i++) begin
            got = ram[chk_addr[i] >> 2];
            assert (got === chk_val[i]) begin
                n_pass++;
                $display("Pass %0d %s ok", pass_no, chk_name[i]);
            end else begin
                n_fail++;
                $display("ERR %0t: pass %0d %s at %h expected %h got %h", $time, pass_no,
                         chk_name[i], chk_addr[i], chk_val[i], got);
            end
        end
    endtask

    initial begin
        CLK = 1'b0;
        rst_n = 1'b0;
        mem_ready = 1'b1;
        wait_mode = 1'b0;
        wait_left = 0;
        seed = 32'h2a4d;
        n_pass = 0;
        n_fail = 0;
        timed_out = 1'b0;
        build_program();
        build_checks();
        run_pass(1, 1'b0, timed_out);
        if (!timed_out) begin
            check_results(1);
            run_pass(2, 1'b1, timed_out);
            if (!timed_out) begin
                check_results(2);
            end
        end
        $display("Checks: %0d passed, %0d failed", n_pass, n_fail);
        if (!timed_out && n_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/cpu_top.sv ====
// Processor top level
// Pipeline datapath behind a single unified memory port
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_top #(
    parameter isa_pkg::word_t PC_INIT = `CPU_PC_INIT
) (
    input  logic           CLK,
    input  logic           rst_n,
    input  isa_pkg::word_t mem_rdata,
    input  logic           mem_ready,
    output logic           mem_ren,
    output logic           mem_wen,
    output isa_pkg::word_t mem_addr,
    output isa_pkg::word_t mem_wdata,
    output logic           halt
);

    logic           ihit, dhit, dmem_ren, dmem_wen;
    isa_pkg::word_t imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;

    datapath #(.PC_INIT(PC_INIT)) u_datapath (
        .CLK(CLK), .rst_n(rst_n), .ihit(ihit), .imem_load(imem_load),
        .dhit(dhit), .dmem_load(dmem_load), .imem_addr(imem_addr),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store), .halt(halt)
    );

    memory_control u_memctl (
        .CLK(CLK), .rst_n(rst_n), .imem_addr(imem_addr), .dmem_ren(dmem_ren),
        .dmem_wen(dmem_wen), .dmem_addr(dmem_addr), .dmem_store(dmem_store),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready), .ihit(ihit),
        .imem_load(imem_load), .dhit(dhit), .dmem_load(dmem_load),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

endmodule

// ==== logic/memory_control.sv ====
// Unified memory arbiter
// Data accesses go first, then the instruction fetch completes the step
`timescale 1ns/100ps

module memory_control (
    input  logic           CLK,
    input  logic           rst_n,
    input  isa_pkg::word_t imem_addr,
    input  logic           dmem_ren,
    input  logic           dmem_wen,
    input  isa_pkg::word_t dmem_addr,
    input  isa_pkg::word_t dmem_store,
    input  isa_pkg::word_t mem_rdata,
    input  logic           mem_ready,
    output logic           ihit,
    output isa_pkg::word_t imem_load,
    output logic           dhit,
    output isa_pkg::word_t dmem_load,
    output logic           mem_ren,
    output logic           mem_wen,
    output isa_pkg::word_t mem_addr,
    output isa_pkg::word_t mem_wdata
);

    logic fetch_on;
    logic done;
    logic d_req;

    // Data access still owed for the EX/MEM instruction
    assign d_req = (dmem_ren || dmem_wen) && !done;

    assign mem_ren   = d_req ? dmem_ren : fetch_on;
    assign mem_wen   = d_req && dmem_wen;
    assign mem_addr  = d_req ? dmem_addr : imem_addr;
    assign mem_wdata = dmem_store;
    assign ihit      = fetch_on && !d_req && mem_ready;
    assign imem_load = mem_rdata;
    assign dhit      = done;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            fetch_on <= 1'b0;
            done     <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (d_req && mem_ready) begin
                done <= 1'b1;
            end else if (ihit) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (d_req && dmem_ren && mem_ready) begin
            dmem_load <= mem_rdata;
        end
    end

endmodule

// ==== logic/datapath.sv ====
// Five-stage pipeline datapath
// PC, stage registers, extender and muxes, stepped by each instruction hit
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module datapath #(
    parameter isa_pkg::word_t PC_INIT = `CPU_PC_INIT
) (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           ihit,
    input  isa_pkg::word_t imem_load,
    input  logic           dhit,
    input  isa_pkg::word_t dmem_load,
    output isa_pkg::word_t imem_addr,
    output logic           dmem_ren,
    output logic           dmem_wen,
    output isa_pkg::word_t dmem_addr,
    output isa_pkg::word_t dmem_store,
    output logic           halt
);

    logic               step;
    isa_pkg::word_t     pc, pc4;
    // IF/ID
    isa_pkg::instr_u    ifid_instr;
    isa_pkg::word_t     ifid_pc4;
    // ID decode and operands
    pipe_pkg::alu_op_t  cu_alu_op;
    pipe_pkg::reg_dst_t cu_reg_dst;
    logic               cu_alu_src, cu_ext_op, cu_upper_imm, cu_reg_wen, cu_mem_to_reg;
    logic               cu_dmem_ren, cu_dmem_wen, cu_branch, cu_branch_ne;
    logic               cu_jump, cu_jump_reg, cu_link, cu_halt;
    isa_pkg::word_t     rdat1, rdat2, imm_ext;
    // ID/EX
    pipe_pkg::alu_op_t  idex_alu_op;
    pipe_pkg::reg_dst_t idex_reg_dst;
    logic               idex_alu_src, idex_reg_wen, idex_mem_to_reg, idex_dmem_ren;
    logic               idex_dmem_wen, idex_branch, idex_branch_ne, idex_jump;
    logic               idex_jump_reg, idex_link, idex_halt, idex_equal;
    isa_pkg::word_t     idex_pc4, idex_rdat1, idex_rdat2, idex_imm;
    isa_pkg::instr_u    idex_instr;
    // EX
    isa_pkg::word_t     alu_b, alu_out, ex_target;
    logic               ex_taken;
    // EX/MEM
    pipe_pkg::reg_dst_t exmem_reg_dst;
    logic               exmem_reg_wen, exmem_mem_to_reg, exmem_link, exmem_halt;
    logic               exmem_dmem_ren, exmem_dmem_wen, exmem_taken;
    isa_pkg::word_t     exmem_pc4, exmem_alu, exmem_rdat2, exmem_target;
    isa_pkg::regbits_t  exmem_rt, exmem_rd;
    // MEM/WB
    pipe_pkg::reg_dst_t memwb_reg_dst;
    logic               memwb_reg_wen, memwb_mem_to_reg, memwb_link;
    isa_pkg::word_t     memwb_pc4, memwb_alu, memwb_load, wdat;
    isa_pkg::regbits_t  memwb_rt, memwb_rd, wsel;

    // A halt in EX/MEM freezes the whole pipe
    assign step = ihit && !exmem_halt;
    assign pc4  = pc + 32'd4;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc <= PC_INIT;
        end else if (step) begin
            pc <= exmem_taken ? exmem_target : pc4;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            ifid_instr <= '0;
        end else if (step) begin
            ifid_instr <= imem_load;
            ifid_pc4   <= pc4;
        end
    end

    control_unit u_control (
        .instr(ifid_instr), .alu_op(cu_alu_op), .alu_src(cu_alu_src),
        .ext_op(cu_ext_op), .upper_imm(cu_upper_imm), .reg_dst(cu_reg_dst),
        .reg_wen(cu_reg_wen), .mem_to_reg(cu_mem_to_reg), .dmem_ren(cu_dmem_ren),
        .dmem_wen(cu_dmem_wen), .branch(cu_branch), .branch_ne(cu_branch_ne),
        .jump(cu_jump), .jump_reg(cu_jump_reg), .link(cu_link), .halt(cu_halt)
    );

    register_file u_regs (
        .CLK(CLK), .rst_n(rst_n), .wen(memwb_reg_wen), .wsel(wsel), .wdat(wdat),
        .rsel1(ifid_instr.r.rs), .rsel2(ifid_instr.r.rt), .rdat1(rdat1), .rdat2(rdat2)
    );

    // Immediate: lui, sign or zero extension
    assign imm_ext = cu_upper_imm ? {ifid_instr.i.imm, 16'b0} :
                     cu_ext_op    ? {{16{ifid_instr.i.imm[15]}}, ifid_instr.i.imm} :
                                    {16'b0, ifid_instr.i.imm};

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            {idex_alu_src, idex_reg_wen, idex_mem_to_reg, idex_dmem_ren} <= '0;
            {idex_dmem_wen, idex_branch, idex_branch_ne, idex_jump} <= '0;
            {idex_jump_reg, idex_link, idex_halt} <= '0;
            idex_alu_op  <= pipe_pkg::alu_add;
            idex_reg_dst <= pipe_pkg::dst_rt;
        end else if (step) begin
            {idex_alu_src, idex_reg_wen, idex_mem_to_reg, idex_dmem_ren} <=
                {cu_alu_src, cu_reg_wen, cu_mem_to_reg, cu_dmem_ren};
            {idex_dmem_wen, idex_branch, idex_branch_ne, idex_jump} <=
                {cu_dmem_wen, cu_branch, cu_branch_ne, cu_jump};
            {idex_jump_reg, idex_link, idex_halt} <= {cu_jump_reg, cu_link, cu_halt};
            idex_alu_op  <= cu_alu_op;
            idex_reg_dst <= cu_reg_dst;
        end
    end

    always_ff @(posedge CLK) begin
        if (step) begin
            idex_pc4   <= ifid_pc4;
            idex_rdat1 <= rdat1;
            idex_rdat2 <= rdat2;
            idex_imm   <= imm_ext;
            idex_instr <= ifid_instr;
            idex_equal <= (rdat1 == rdat2);
        end
    end

    assign alu_b = idex_alu_src ? idex_imm : idex_rdat2;

    alu u_alu (
        .port_a(idex_rdat1), .port_b(alu_b), .alu_op(idex_alu_op),
        .shamt(idex_instr.r.shamt), .out_port(alu_out), .zero()
    );

    // Branch, jump or register target
    assign ex_taken  = idex_jump || idex_jump_reg ||
                       (idex_branch && (idex_equal ^ idex_branch_ne));
    assign ex_target = idex_jump_reg ? idex_rdat1 :
                       idex_jump     ? {idex_pc4[31:28], idex_instr.j.addr, 2'b00} :
                                       idex_pc4 + {idex_imm[29:0], 2'b00};

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            {exmem_reg_wen, exmem_mem_to_reg, exmem_link, exmem_halt} <= '0;
            {exmem_dmem_ren, exmem_dmem_wen, exmem_taken} <= '0;
            exmem_reg_dst <= pipe_pkg::dst_rt;
        end else if (step) begin
            {exmem_reg_wen, exmem_mem_to_reg, exmem_link, exmem_halt} <=
                {idex_reg_wen, idex_mem_to_reg, idex_link, idex_halt};
            {exmem_dmem_ren, exmem_dmem_wen, exmem_taken} <=
                {idex_dmem_ren, idex_dmem_wen, ex_taken};
            exmem_reg_dst <= idex_reg_dst;
        end
    end

    always_ff @(posedge CLK) begin
        if (step) begin
            exmem_pc4    <= idex_pc4;
            exmem_alu    <= alu_out;
            exmem_rdat2  <= idex_rdat2;
            exmem_target <= ex_target;
            exmem_rt     <= idex_instr.r.rt;
            exmem_rd     <= idex_instr.r.rd;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            {memwb_reg_wen, memwb_mem_to_reg, memwb_link} <= '0;
            memwb_reg_dst <= pipe_pkg::dst_rt;
        end else if (step) begin
            {memwb_reg_wen, memwb_mem_to_reg, memwb_link} <=
                {exmem_reg_wen, exmem_mem_to_reg, exmem_link};
            memwb_reg_dst <= exmem_reg_dst;
        end
    end

    always_ff @(posedge CLK) begin
        if (step) begin
            memwb_pc4 <= exmem_pc4;
            memwb_alu <= exmem_alu;
            memwb_rt  <= exmem_rt;
            memwb_rd  <= exmem_rd;
        end
        // Held load data is valid once the data access is done
        if (step && dhit) begin
            memwb_load <= dmem_load;
        end
    end

    always_comb begin
        case (memwb_reg_dst)
            pipe_pkg::dst_rd: wsel = memwb_rd;
            pipe_pkg::dst_ra: wsel = 5'd31;
            default:          wsel = memwb_rt;
        endcase
    end

    assign wdat = memwb_mem_to_reg ? memwb_load :
                  memwb_link       ? memwb_pc4  : memwb_alu;

    assign imem_addr  = pc;
    assign dmem_ren   = exmem_dmem_ren;
    assign dmem_wen   = exmem_dmem_wen;
    assign dmem_addr  = exmem_alu;
    assign dmem_store = exmem_rdat2;
    assign halt       = exmem_halt;

endmodule

// ==== logic/control_unit.sv ====
// Instruction decoder
// Maps opcode and funct onto the datapath control signals
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module control_unit (
    input  isa_pkg::instr_u    instr,
    output pipe_pkg::alu_op_t  alu_op,
    output logic               alu_src,
    output logic               ext_op,
    output logic               upper_imm,
    output pipe_pkg::reg_dst_t reg_dst,
    output logic               reg_wen,
    output logic               mem_to_reg,
    output logic               dmem_ren,
    output logic               dmem_wen,
    output logic               branch,
    output logic               branch_ne,
    output logic               jump,
    output logic               jump_reg,
    output logic               link,
    output logic               halt
);

    always_comb begin
        // Nop unless the encoding is recognized
        alu_op     = pipe_pkg::alu_add;
        alu_src    = 1'b0;
        ext_op     = 1'b0;
        upper_imm  = 1'b0;
        reg_dst    = pipe_pkg::dst_rt;
        reg_wen    = 1'b0;
        mem_to_reg = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        link       = 1'b0;
        halt       = 1'b0;
        if (instr == `CPU_HALT_WORD) begin
            halt = 1'b1;
        end else begin
            case (instr.r.opcode)
                isa_pkg::op_rtype: begin
                    reg_dst = pipe_pkg::dst_rd;
                    reg_wen = 1'b1;
                    case (instr.r.funct)
                        isa_pkg::fn_addu: alu_op = pipe_pkg::alu_add;
                        isa_pkg::fn_subu: alu_op = pipe_pkg::alu_sub;
                        isa_pkg::fn_and:  alu_op = pipe_pkg::alu_and;
                        isa_pkg::fn_or:   alu_op = pipe_pkg::alu_or;
                        isa_pkg::fn_xor:  alu_op = pipe_pkg::alu_xor;
                        isa_pkg::fn_nor:  alu_op = pipe_pkg::alu_nor;
                        isa_pkg::fn_slt:  alu_op = pipe_pkg::alu_slt;
                        isa_pkg::fn_sltu: alu_op = pipe_pkg::alu_sltu;
                        isa_pkg::fn_sll:  alu_op = pipe_pkg::alu_sll;
                        isa_pkg::fn_srl:  alu_op = pipe_pkg::alu_srl;
                        isa_pkg::fn_jr: begin
                            reg_wen  = 1'b0;
                            jump_reg = 1'b1;
                        end
                        default: reg_wen = 1'b0;
                    endcase
                end
                isa_pkg::op_addiu,
                isa_pkg::op_slti: begin
                    alu_op  = (instr.r.opcode == isa_pkg::op_slti) ?
                              pipe_pkg::alu_slt : pipe_pkg::alu_add;
                    alu_src = 1'b1;
                    ext_op  = 1'b1;
                    reg_wen = 1'b1;
                end
                isa_pkg::op_andi,
                isa_pkg::op_ori,
                isa_pkg::op_xori: begin
                    case (instr.r.opcode)
                        isa_pkg::op_andi: alu_op = pipe_pkg::alu_and;
                        isa_pkg::op_ori:  alu_op = pipe_pkg::alu_or;
                        default:          alu_op = pipe_pkg::alu_xor;
                    endcase
                    alu_src = 1'b1;
                    reg_wen = 1'b1;
                end
                isa_pkg::op_lui: begin
                    alu_src   = 1'b1;
                    upper_imm = 1'b1;
                    reg_wen   = 1'b1;
                end
                isa_pkg::op_lw: begin
                    alu_src    = 1'b1;
                    ext_op     = 1'b1;
                    reg_wen    = 1'b1;
                    mem_to_reg = 1'b1;
                    dmem_ren   = 1'b1;
                end
                isa_pkg::op_sw: begin
                    alu_src  = 1'b1;
                    ext_op   = 1'b1;
                    dmem_wen = 1'b1;
                end
                isa_pkg::op_beq,
                isa_pkg::op_bne: begin
                    ext_op    = 1'b1;
                    branch    = 1'b1;
                    branch_ne = (instr.r.opcode == isa_pkg::op_bne);
                end
                isa_pkg::op_jal: begin
                    jump    = 1'b1;
                    link    = 1'b1;
                    reg_dst = pipe_pkg::dst_ra;
                    reg_wen = 1'b1;
                end
                isa_pkg::op_j: jump = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/alu.sv ====
// Combinational ALU for the ten pipeline operations
`timescale 1ns/100ps

module alu (
    input  isa_pkg::word_t    port_a,
    input  isa_pkg::word_t    port_b,
    input  pipe_pkg::alu_op_t alu_op,
    input  logic [4:0]        shamt,
    output isa_pkg::word_t    out_port,
    output logic              zero
);

    always_comb begin
        case (alu_op)
            pipe_pkg::alu_sub: out_port = port_a - port_b;
            pipe_pkg::alu_and: out_port = port_a & port_b;
            pipe_pkg::alu_or:  out_port = port_a | port_b;
            pipe_pkg::alu_xor: out_port = port_a ^ port_b;
            pipe_pkg::alu_nor: out_port = ~(port_a | port_b);
            pipe_pkg::alu_slt: begin
                out_port = {31'b0, $signed(port_a) < $signed(port_b)};
            end
            pipe_pkg::alu_sltu: begin
                out_port = {31'b0, port_a < port_b};
            end
            // Shifts move the B operand
            pipe_pkg::alu_sll: out_port = port_b << shamt;
            pipe_pkg::alu_srl: out_port = port_b >> shamt;
            default:           out_port = port_a + port_b;
        endcase
    end

    assign zero = (out_port == '0);

endmodule

// ==== logic/register_file.sv ====
// Register file with two read ports and one write port
// Register zero reads as zero, reads see a same-cycle write
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module register_file (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              wen,
    input  isa_pkg::regbits_t wsel,
    input  isa_pkg::word_t    wdat,
    input  isa_pkg::regbits_t rsel1,
    input  isa_pkg::regbits_t rsel2,
    output isa_pkg::word_t    rdat1,
    output isa_pkg::word_t    rdat2
);

    isa_pkg::word_t regs [`CPU_REG_COUNT];
    logic           wr_live;

    // Register zero is never written
    assign wr_live = wen && (wsel != '0);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_live) begin
            regs[wsel] <= wdat;
        end
    end

    // Write-through bypass
    assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
    assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// ==== logic/pipe_pkg.sv ====
// Pipeline control types
// ALU operation codes and write-register selection
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl
    } alu_op_t;

    // Destination register source
    typedef enum logic [1:0] {
        dst_rt,
        dst_rd,
        dst_ra
    } reg_dst_t;

endpackage

// ==== logic/isa_pkg.sv ====
// Instruction-set types for the MIPS subset
// Words, register indices, encodings and the instruction formats
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        regbits_t   rs;
        regbits_t   rt;
        regbits_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_t;

    typedef struct packed {
        opcode_t     opcode;
        regbits_t    rs;
        regbits_t    rt;
        logic [15:0] imm;
    } i_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] addr;
    } j_t;

    // One fetched word, seen in each of the three formats
    typedef union packed {
        r_t r;
        i_t i;
        j_t j;
    } instr_u;

endpackage

// ==== logic/cpu_cfg.svh ====
// CPU configuration macros
// Reset PC, register count and the halt encoding
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Program counter value after reset
`define CPU_PC_INIT 32'h0000_0000

// Architectural register count
`define CPU_REG_COUNT 32

// All-ones word stops the pipeline
`define CPU_HALT_WORD 32'hffff_ffff

`endif
